// File: hw/spim_defs.svh
`ifndef SPIM_DEFS_SVH
`define SPIM_DEFS_SVH

`define SPIM_BUF_BYTES   256
`define SPIM_NUM_CS      2
`define SPIM_ADDR_W      12
`define SPIM_DATA_W      32
`define SPIM_BUF_AW      8          // byte address into the buffer
`define SPIM_DIV_W       9
`define SPIM_LEN_W       9          // 0 to 256 bytes

`define SPIM_BUF_SEL_BIT 11
`define SPIM_REG_CTRL    12'h000
`define SPIM_REG_CS      12'h004
`define SPIM_REG_XFER    12'h008

`define SPIM_LOOP_BIT    9          // loopback flag in ctrl above the divider
`define SPIM_GO_BIT      16
`define SPIM_BUSY_BIT    17

`define SPIM_RESP_OKAY   2'b00
`define SPIM_RESP_SLVERR 2'b10

`endif

// File: hw/spim_pkg.sv
`default_nettype none

`include "spim_defs.svh"

package spim_pkg;

	typedef logic [`SPIM_ADDR_W-1:0] axil_addr_t;
	typedef logic [`SPIM_DATA_W-1:0] axil_data_t;
	typedef logic [`SPIM_DATA_W/8-1:0] axil_strb_t;
	typedef logic [1:0] axil_resp_t;
	typedef logic [`SPIM_BUF_AW-1:0] buf_addr_t;
	typedef logic [7:0] buf_byte_t;
	typedef logic [`SPIM_DIV_W-1:0] spi_div_t;     // half period minus one
	typedef logic [`SPIM_LEN_W-1:0] xfer_len_t;
	typedef logic [`SPIM_NUM_CS-1:0] cs_vec_t;

	typedef struct packed {
		logic awvalid;
		axil_addr_t awaddr;
		logic wvalid;
		axil_data_t wdata;
		axil_strb_t wstrb;
		logic bready;
		logic arvalid;
		axil_addr_t araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		axil_resp_t bresp;
		logic arready;
		logic rvalid;
		axil_data_t rdata;
		axil_resp_t rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic valid;
		logic write;
		axil_addr_t addr;
		axil_data_t wdata;
		axil_strb_t wstrb;
	} reg_req_t;

	typedef struct packed {
		logic valid;
		logic err;
		axil_data_t rdata;
	} reg_rsp_t;

	typedef struct packed {
		spi_div_t divider;
		logic loopback;
	} spi_cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		SHIFT,
		STORE,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

// File: hw/spim_axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "spim_defs.svh"

module spim_axil_slave (
	input  logic                 clk,
	input  logic                 arst_n,
	input  spim_pkg::axil_req_t  axil_req,
	output spim_pkg::axil_rsp_t  axil_rsp,
	output spim_pkg::reg_req_t   reg_req,
	input  spim_pkg::reg_rsp_t   reg_rsp
);
	import spim_pkg::*;

	logic wr_go;
	logic rd_go;
	logic rd_free;
	logic wr_inflight_q;
	logic rd_inflight_q;
	logic rsp_wr;
	logic rsp_rd;
	logic bvalid_q;
	logic rvalid_q;
	axil_resp_t bresp_q;
	axil_resp_t rresp_q;
	axil_data_t rdata_q;

	// address and data must arrive together
	assign wr_go = axil_req.awvalid && axil_req.wvalid && !wr_inflight_q && !bvalid_q;
	assign rd_free = !rd_inflight_q && !rvalid_q;
	assign rd_go = axil_req.arvalid && rd_free && !wr_go;   // write wins a tie

	assign rsp_wr = reg_rsp.valid && wr_inflight_q;
	assign rsp_rd = reg_rsp.valid && rd_inflight_q;

	always_comb begin
		reg_req.valid = wr_go || rd_go;
		reg_req.write = wr_go;
		reg_req.addr  = wr_go ? axil_req.awaddr : axil_req.araddr;
		reg_req.wdata = axil_req.wdata;
		reg_req.wstrb = axil_req.wstrb;
	end

	always_comb begin
		axil_rsp.awready = wr_go;
		axil_rsp.wready  = wr_go;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.arready = rd_free && !wr_go;
		axil_rsp.rvalid  = rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_inflight_q <= 1'b0;
			rd_inflight_q <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			wr_inflight_q <= wr_go;
			rd_inflight_q <= rd_go;
			if (rsp_wr)
				bvalid_q <= 1'b1;
			else if (axil_req.bready)
				bvalid_q <= 1'b0;
			if (rsp_rd)
				rvalid_q <= 1'b1;
			else if (axil_req.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_wr)
			bresp_q <= reg_rsp.err ? `SPIM_RESP_SLVERR : `SPIM_RESP_OKAY;
		if (rsp_rd) begin
			rdata_q <= reg_rsp.rdata;
			rresp_q <= reg_rsp.err ? `SPIM_RESP_SLVERR : `SPIM_RESP_OKAY;
		end
	end

	a_bvalid_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q)
	);

	a_rdata_stable: assert property (
		@(posedge clk) disable iff (!arst_n)
		rvalid_q && !axil_req.rready |=> rvalid_q && $stable(rdata_q)
	);

endmodule

`default_nettype wire

// File: hw/spim_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "spim_defs.svh"

module spim_ctrl_regs (
	input  logic                      clk,
	input  logic                      arst_n,
	input  spim_pkg::reg_req_t        reg_req,
	output spim_pkg::reg_rsp_t        reg_rsp,
	output logic [`SPIM_BUF_AW-3:0]   buf_host_addr,
	output spim_pkg::axil_strb_t      buf_host_wstrb,
	output spim_pkg::axil_data_t      buf_host_wdata,
	input  spim_pkg::axil_data_t      buf_host_rdata,
	output spim_pkg::spi_cfg_t        cfg,
	output logic                      xfer_start,
	output spim_pkg::xfer_len_t       xfer_length,
	input  logic                      xfer_done,
	output spim_pkg::cs_vec_t         ncs
);
	import spim_pkg::*;

	logic buf_sel;
	logic is_ctrl;
	logic is_cs;
	logic is_xfer;
	logic req_err;
	logic wr_ok;
	logic go;
	axil_data_t reg_rd;
	spi_cfg_t cfg_q;
	cs_vec_t cs_q;
	xfer_len_t len_q;
	logic busy_q;
	logic start_q;
	logic rsp_valid_q;
	logic rsp_err_q;
	logic rsp_buf_q;
	axil_data_t reg_rd_q;

	assign buf_sel = reg_req.addr[`SPIM_BUF_SEL_BIT];
	assign is_ctrl = reg_req.addr == `SPIM_REG_CTRL;
	assign is_cs   = reg_req.addr == `SPIM_REG_CS;
	assign is_xfer = reg_req.addr == `SPIM_REG_XFER;

	// unmapped, or touching xfer state while a transfer runs
	assign req_err = !(buf_sel || is_ctrl || is_cs || is_xfer) ||
		(reg_req.write && busy_q && (buf_sel || is_xfer));
	assign wr_ok = reg_req.valid && reg_req.write && !req_err;
	assign go = wr_ok && is_xfer && reg_req.wdata[`SPIM_GO_BIT];

	assign buf_host_addr  = reg_req.addr[`SPIM_BUF_AW-1:2];
	assign buf_host_wdata = reg_req.wdata;
	assign buf_host_wstrb = (wr_ok && buf_sel) ? reg_req.wstrb : '0;

	assign cfg = cfg_q;
	assign xfer_start = start_q;
	assign xfer_length = len_q;
	assign ncs = ~cs_q;     // 1 written selects the device

	always_comb begin
		reg_rd = '0;
		if (is_ctrl) begin
			reg_rd[`SPIM_DIV_W-1:0] = cfg_q.divider;
			reg_rd[`SPIM_LOOP_BIT] = cfg_q.loopback;
		end else if (is_cs) begin
			reg_rd[`SPIM_NUM_CS-1:0] = cs_q;
		end else if (is_xfer) begin
			reg_rd[`SPIM_LEN_W-1:0] = len_q;
			reg_rd[`SPIM_BUSY_BIT] = busy_q;   // go reads back as 0
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_q <= '0;
			cs_q <= '0;
			len_q <= '0;
			busy_q <= 1'b0;
			start_q <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= reg_req.valid;
			start_q <= go;
			if (go)
				busy_q <= 1'b1;
			else if (xfer_done)
				busy_q <= 1'b0;
			if (wr_ok && is_ctrl) begin
				cfg_q.divider <= reg_req.wdata[`SPIM_DIV_W-1:0];
				cfg_q.loopback <= reg_req.wdata[`SPIM_LOOP_BIT];
			end
			if (wr_ok && is_cs)
				cs_q <= reg_req.wdata[`SPIM_NUM_CS-1:0];
			if (wr_ok && is_xfer)
				len_q <= reg_req.wdata[`SPIM_LEN_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		rsp_err_q <= req_err;
		rsp_buf_q <= buf_sel && !reg_req.write;
		reg_rd_q <= reg_rd;
	end

	// buffer data arrives a cycle after the address
	always_comb begin
		reg_rsp.valid = rsp_valid_q;
		reg_rsp.err   = rsp_err_q;
		reg_rsp.rdata = rsp_buf_q ? buf_host_rdata : reg_rd_q;
	end

	// done only ends a running transfer and never meets a new start
	a_no_start_busy: assert property (
		@(posedge clk) disable iff (!arst_n)
		xfer_done |-> busy_q && !xfer_start
	);

endmodule

`default_nettype wire

// File: hw/spim_xfer_buf.sv
`timescale 1ns/1ps
`default_nettype none

`include "spim_defs.svh"

module spim_xfer_buf (
	input  logic                     clk,
	input  logic [`SPIM_BUF_AW-3:0]  host_addr,
	input  spim_pkg::axil_strb_t     host_wstrb,
	input  spim_pkg::axil_data_t     host_wdata,
	output spim_pkg::axil_data_t     host_rdata,
	input  spim_pkg::buf_addr_t      seq_addr,
	input  logic                     seq_we,
	input  spim_pkg::buf_byte_t      seq_wdata,
	output spim_pkg::buf_byte_t      seq_rdata
);
	import spim_pkg::*;

	localparam int WORDS = `SPIM_BUF_BYTES / 4;

	buf_byte_t seq_lane [4];
	logic [1:0] seq_lane_q;

	// one little endian memory per byte lane
	for (genvar l = 0; l < 4; l++) begin : g_lane
		buf_byte_t mem [WORDS];
		buf_byte_t host_q;
		buf_byte_t seq_q;

		always_ff @(posedge clk) begin
			if (host_wstrb[l])
				mem[host_addr] <= host_wdata[8*l +: 8];
			if (seq_we && seq_addr[1:0] == 2'(l))
				mem[seq_addr[`SPIM_BUF_AW-1:2]] <= seq_wdata;
			host_q <= mem[host_addr];
			seq_q <= mem[seq_addr[`SPIM_BUF_AW-1:2]];
		end

		assign host_rdata[8*l +: 8] = host_q;
		assign seq_lane[l] = seq_q;
	end

	always_ff @(posedge clk)
		seq_lane_q <= seq_addr[1:0];

	assign seq_rdata = seq_lane[seq_lane_q];

endmodule

`default_nettype wire

// File: hw/spim_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module spim_sequencer (
	input  logic                  clk,
	input  logic                  arst_n,
	input  spim_pkg::spi_cfg_t    cfg,
	input  logic                  xfer_start,
	input  spim_pkg::xfer_len_t   xfer_length,
	output logic                  xfer_done,
	output spim_pkg::buf_addr_t   buf_addr,
	output logic                  buf_we,
	output spim_pkg::buf_byte_t   buf_wdata,
	input  spim_pkg::buf_byte_t   buf_rdata,
	input  logic                  miso,
	output logic                  mosi,
	output logic                  sclk
);
	import spim_pkg::*;

	seq_state_t state_q;
	buf_addr_t addr_q;
	xfer_len_t cnt_q;
	spi_div_t div_cnt_q;
	logic [2:0] bit_cnt_q;
	logic fetched_q;
	logic sclk_q;
	buf_byte_t tx_q;
	buf_byte_t rx_q;
	logic miso_in;
	logic half_end;
	logic rise;

	assign miso_in = cfg.loopback ? ~tx_q[7] : miso;
	assign half_end = div_cnt_q == cfg.divider;
	assign rise = state_q == SHIFT && half_end && !sclk_q;

	assign mosi = tx_q[7];
	assign sclk = sclk_q;
	assign buf_addr = addr_q;
	assign buf_we = state_q == STORE;
	assign buf_wdata = rx_q;
	assign xfer_done = state_q == DONE;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			addr_q <= '0;
			cnt_q <= '0;
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
			fetched_q <= 1'b0;
			sclk_q <= 1'b0;
			tx_q <= '0;
		end else begin
			case (state_q)
			IDLE: if (xfer_start) begin
				addr_q <= '0;
				cnt_q <= '0;
				state_q <= LOAD;
			end
			LOAD: if (cnt_q == xfer_length) begin
				state_q <= DONE;
			end else if (!fetched_q) begin
				fetched_q <= 1'b1;      // read in flight
			end else begin
				tx_q <= buf_rdata;
				fetched_q <= 1'b0;
				div_cnt_q <= '0;
				bit_cnt_q <= '0;
				state_q <= SHIFT;
			end
			SHIFT: if (!half_end) begin
				div_cnt_q <= div_cnt_q + 1'b1;
			end else begin
				div_cnt_q <= '0;
				sclk_q <= !sclk_q;
				if (sclk_q) begin       // next bit out on falling edge
					tx_q <= {tx_q[6:0], 1'b0};
					bit_cnt_q <= bit_cnt_q + 1'b1;
					if (bit_cnt_q == 3'd7)
						state_q <= STORE;
				end
			end
			STORE: begin
				addr_q <= addr_q + 1'b1;
				cnt_q <= cnt_q + 1'b1;
				state_q <= LOAD;
			end
			DONE: state_q <= IDLE;
			default: state_q <= IDLE;
			endcase
		end
	end

	// sample on rising sclk
	always_ff @(posedge clk)
		if (rise)
			rx_q <= {rx_q[6:0], miso_in};

	a_sclk_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		state_q == IDLE |-> !sclk
	);

endmodule

`default_nettype wire

// File: hw/spim_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spim_defs.svh"

module spim_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  spim_pkg::axil_req_t  axil_req,
	output spim_pkg::axil_rsp_t  axil_rsp,
	input  logic                 miso,
	output logic                 mosi,
	output logic                 sclk,
	output spim_pkg::cs_vec_t    ncs
);
	import spim_pkg::*;

	reg_req_t reg_req;
	reg_rsp_t reg_rsp;
	logic [`SPIM_BUF_AW-3:0] buf_host_addr;
	axil_strb_t buf_host_wstrb;
	axil_data_t buf_host_wdata;
	axil_data_t buf_host_rdata;
	spi_cfg_t cfg;
	logic xfer_start;
	logic xfer_done;
	xfer_len_t xfer_length;
	buf_addr_t seq_addr;
	logic seq_we;
	buf_byte_t seq_wdata;
	buf_byte_t seq_rdata;

	spim_axil_slave axil_i (
		.clk(clk), .arst_n(arst_n),
		.axil_req(axil_req), .axil_rsp(axil_rsp),
		.reg_req(reg_req), .reg_rsp(reg_rsp)
	);

	spim_ctrl_regs regs_i (
		.clk(clk), .arst_n(arst_n),
		.reg_req(reg_req), .reg_rsp(reg_rsp),
		.buf_host_addr(buf_host_addr), .buf_host_wstrb(buf_host_wstrb),
		.buf_host_wdata(buf_host_wdata), .buf_host_rdata(buf_host_rdata),
		.cfg(cfg), .xfer_start(xfer_start), .xfer_length(xfer_length),
		.xfer_done(xfer_done), .ncs(ncs)
	);

	spim_xfer_buf buf_i (
		.clk(clk),
		.host_addr(buf_host_addr), .host_wstrb(buf_host_wstrb),
		.host_wdata(buf_host_wdata), .host_rdata(buf_host_rdata),
		.seq_addr(seq_addr), .seq_we(seq_we),
		.seq_wdata(seq_wdata), .seq_rdata(seq_rdata)
	);

	spim_sequencer seq_i (
		.clk(clk), .arst_n(arst_n),
		.cfg(cfg), .xfer_start(xfer_start), .xfer_length(xfer_length),
		.xfer_done(xfer_done),
		.buf_addr(seq_addr), .buf_we(seq_we),
		.buf_wdata(seq_wdata), .buf_rdata(seq_rdata),
		.miso(miso), .mosi(mosi), .sclk(sclk)
	);

endmodule

`default_nettype wire

// File: sim/spim_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spim_defs.svh"

module spim_tb;
	import spim_pkg::*;

	localparam int HS_TIMEOUT = 100;
	localparam int POLL_LIMIT = 10000;
	localparam axil_addr_t BUF_BASE = 12'h800;
	localparam int GO = 1 << `SPIM_GO_BIT;

	logic clk;
	logic arst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic miso;
	logic mosi;
	logic sclk;
	cs_vec_t ncs;

	int errors = 0;
	int model_errors = 0;
	int tests = 0;
	integer seed = 32'h8ef0_84d5;
	buf_byte_t shadow [`SPIM_BUF_BYTES];     // expected buffer contents

	logic model_en;
	logic sclk_d = 1'b0;
	logic [2:0] model_bits = '0;
	buf_byte_t model_in = '0;
	buf_byte_t model_out = 8'h5a;
	buf_byte_t model_reply = 8'h5a;
	int half_cnt = 0;
	buf_byte_t seen_q [$];

	spim_top dut_i (
		.clk(clk), .arst_n(arst_n),
		.axil_req(axil_req), .axil_rsp(axil_rsp),
		.miso(miso), .mosi(mosi), .sclk(sclk), .ncs(ncs)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// mode 0 spi slave echoing the previous byte
	assign miso = model_out[7];

	always @(posedge clk) begin
		sclk_d <= sclk;
		if (!model_en) begin
			model_bits <= '0;
			model_out <= 8'h5a;
			model_reply <= 8'h5a;
			half_cnt <= 0;
		end else begin
			half_cnt <= half_cnt + 1;
			if (sclk && !sclk_d) begin
				model_in <= {model_in[6:0], mosi};
				model_bits <= model_bits + 1'b1;
				if (model_bits == 3'd7) begin
					model_reply <= {model_in[6:0], mosi};
					seen_q.push_back({model_in[6:0], mosi});
				end
				if (model_bits != 3'd0 && half_cnt != 4) begin   // first low phase follows LOAD
					$display("CHECK FAILED sclk low phase: got %h, expected %h", half_cnt, 4);
					model_errors++;
				end
				half_cnt <= 1;
			end else if (!sclk && sclk_d) begin
				if (half_cnt != 4) begin
					$display("CHECK FAILED sclk high phase: got %h, expected %h", half_cnt, 4);
					model_errors++;
				end
				model_out <= (model_bits == 3'd0) ? model_reply : {model_out[6:0], 1'b0};
				half_cnt <= 1;
			end
		end
	end

	function automatic int total_errors();
		return errors + model_errors;
	endfunction

	function automatic axil_addr_t word_addr(input int word);
		return BUF_BASE | axil_addr_t'(word << 2);
	endfunction

	task automatic check_data(input string name, input axil_data_t got, input axil_data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input buf_byte_t got, input buf_byte_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic timed_out(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
	endtask

	// hold keeps bready low that many cycles once bvalid is seen
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
			input axil_strb_t strb, input int hold, output axil_resp_t resp);
		int t;
		int i;
		resp = 2'bxx;
		@(posedge clk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr <= addr;
		axil_req.wvalid <= 1'b1;
		axil_req.wdata <= data;
		axil_req.wstrb <= strb;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!axil_rsp.awready && t < HS_TIMEOUT);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		if (!axil_rsp.awready) begin
			timed_out("awready");
			return;
		end
		if (!axil_rsp.wready) begin
			$display("wready was low when awready rose");
			errors++;
		end
		t = 0;
		while (!axil_rsp.bvalid && t < HS_TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (!axil_rsp.bvalid) begin
			timed_out("bvalid");
			return;
		end
		resp = axil_rsp.bresp;
		for (i = 0; i < hold; i++) begin
			@(posedge clk);
			if (!axil_rsp.bvalid) begin
				$display("bvalid dropped while bready was low");
				errors++;
			end
			check_resp("bresp", axil_rsp.bresp, resp);
		end
		axil_req.bready <= 1'b1;
		@(posedge clk);
		axil_req.bready <= 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, input int hold,
			output axil_data_t data, output axil_resp_t resp);
		int t;
		int i;
		data = 'x;
		resp = 2'bxx;
		@(posedge clk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr <= addr;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!axil_rsp.arready && t < HS_TIMEOUT);
		axil_req.arvalid <= 1'b0;
		if (!axil_rsp.arready) begin
			timed_out("arready");
			return;
		end
		t = 0;
		while (!axil_rsp.rvalid && t < HS_TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (!axil_rsp.rvalid) begin
			timed_out("rvalid");
			return;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		for (i = 0; i < hold; i++) begin
			@(posedge clk);
			if (!axil_rsp.rvalid || axil_rsp.arready) begin
				$display("read channel did not hold while rready was low");
				errors++;
			end
			check_data("rdata", axil_rsp.rdata, data);
			check_resp("rresp", axil_rsp.rresp, resp);
		end
		axil_req.rready <= 1'b1;
		@(posedge clk);
		axil_req.rready <= 1'b0;
	endtask

	task automatic reg_write(input axil_addr_t addr, input axil_data_t data);
		axil_resp_t r;
		axil_write(addr, data, 4'hf, 0, r);
		check_resp("bresp", r, `SPIM_RESP_OKAY);
	endtask

	task automatic reg_check(input string name, input axil_addr_t addr, input axil_data_t exp);
		axil_data_t d;
		axil_resp_t r;
		axil_read(addr, 0, d, r);
		check_resp("rresp", r, `SPIM_RESP_OKAY);
		check_data(name, d, exp);
	endtask

	task automatic buf_write(input int word, input axil_data_t data, input axil_strb_t strb);
		axil_resp_t r;
		int b;
		axil_write(word_addr(word), data, strb, 0, r);
		check_resp("bresp", r, `SPIM_RESP_OKAY);
		for (b = 0; b < 4; b++)
			if (strb[b])
				shadow[4*word + b] = data[8*b +: 8];
	endtask

	task automatic check_buf_words(input int first, input int count);
		axil_data_t d;
		axil_resp_t r;
		int w;
		int b;
		for (w = first; w < first + count; w++) begin
			axil_read(word_addr(w), 0, d, r);
			check_resp("rresp", r, `SPIM_RESP_OKAY);
			for (b = 0; b < 4; b++)
				check_byte($sformatf("buf[%0d]", 4*w + b), d[8*b +: 8], shadow[4*w + b]);
		end
	endtask

	task automatic wait_idle();
		axil_data_t d;
		axil_resp_t r;
		int n;
		n = 0;
		do begin
			axil_read(`SPIM_REG_XFER, 0, d, r);
			n++;
		end while (d[`SPIM_BUSY_BIT] === 1'b1 && n < POLL_LIMIT);
		if (d[`SPIM_BUSY_BIT] === 1'b1)
			timed_out("busy to clear");
	endtask

	task automatic report(input string name, input int base);
		int n;
		n = total_errors() - base;
		$display("%-24s %s (%0d errors)", name, n == 0 ? "ok" : "FAILED", n);
		tests++;
	endtask

	task automatic regs_after_reset();
		axil_data_t d;
		axil_resp_t r;
		int base;
		base = total_errors();
		check_data("ncs", 32'(ncs), 32'h3);
		check_data("sclk", 32'(sclk), 32'h0);
		check_data("mosi", 32'(mosi), 32'h0);
		reg_check("ctrl", `SPIM_REG_CTRL, 32'h0);
		reg_check("cs", `SPIM_REG_CS, 32'h0);
		reg_check("xfer", `SPIM_REG_XFER, 32'h0);
		reg_write(`SPIM_REG_CTRL, 32'h0000_0207);
		reg_check("ctrl", `SPIM_REG_CTRL, 32'h0000_0207);
		reg_write(`SPIM_REG_CS, 32'h1);
		reg_check("cs", `SPIM_REG_CS, 32'h1);
		check_data("ncs", 32'(ncs), 32'h2);      // device 0 selected
		reg_write(`SPIM_REG_CS, 32'h0);
		reg_write(`SPIM_REG_CTRL, 32'h0);
		axil_read(12'h00c, 0, d, r);
		check_resp("rresp", r, `SPIM_RESP_SLVERR);
		axil_write(12'h010, 32'h0, 4'hf, 0, r);
		check_resp("bresp", r, `SPIM_RESP_SLVERR);
		report("reset and registers", base);
	endtask

	task automatic buf_strobe_merge();
		int base;
		int w;
		int i;
		base = total_errors();
		for (w = 0; w < 64; w++)
			buf_write(w, $random(seed), 4'hf);
		for (i = 0; i < 24; i++) begin
			w = $random(seed) & 63;
			buf_write(w, $random(seed), axil_strb_t'($random(seed)));
		end
		check_buf_words(0, 64);
		report("buffer byte strobes", base);
	endtask

	task automatic loopback_xfer();
		int base;
		int w;
		int i;
		base = total_errors();
		for (w = 0; w < 4; w++)
			buf_write(w, $random(seed), 4'hf);
		reg_write(`SPIM_REG_CTRL, 1 << `SPIM_LOOP_BIT);
		reg_write(`SPIM_REG_XFER, GO | 16);
		wait_idle();
		for (i = 0; i < 16; i++)
			shadow[i] = ~shadow[i];
		check_buf_words(0, 8);
		report("loopback transfer", base);
	endtask

	task automatic external_xfer();
		buf_byte_t tx [5];
		int seen_base;
		int base;
		int i;
		base = total_errors();
		buf_write(0, $random(seed), 4'hf);
		buf_write(1, $random(seed), 4'hf);
		for (i = 0; i < 5; i++)
			tx[i] = shadow[i];
		seen_base = seen_q.size();
		reg_write(`SPIM_REG_CTRL, 32'h3);
		reg_write(`SPIM_REG_CS, 32'h1);
		model_en <= 1'b1;
		reg_write(`SPIM_REG_XFER, GO | 5);
		wait_idle();
		model_en <= 1'b0;
		reg_write(`SPIM_REG_CS, 32'h0);
		shadow[0] = 8'h5a;
		for (i = 1; i < 5; i++)
			shadow[i] = tx[i-1];
		check_buf_words(0, 2);
		check_data("mosi byte count", seen_q.size() - seen_base, 32'd5);
		for (i = 0; i < 5 && seen_base + i < seen_q.size(); i++)
			check_byte($sformatf("mosi byte %0d", i), seen_q[seen_base + i], tx[i]);
		report("external transfer", base);
	endtask

	task automatic busy_refusal();
		axil_resp_t r;
		int base;
		int i;
		base = total_errors();
		reg_write(`SPIM_REG_CTRL, (1 << `SPIM_LOOP_BIT) | 63);
		reg_write(`SPIM_REG_XFER, GO | 8);
		axil_write(word_addr(10), 32'hdead_beef, 4'hf, 0, r);
		check_resp("bresp", r, `SPIM_RESP_SLVERR);
		axil_write(`SPIM_REG_XFER, GO | 8, 4'hf, 0, r);
		check_resp("bresp", r, `SPIM_RESP_SLVERR);
		wait_idle();
		for (i = 0; i < 8; i++)
			shadow[i] = ~shadow[i];
		check_buf_words(0, 3);
		check_buf_words(10, 1);
		reg_write(`SPIM_REG_XFER, GO);          // zero length
		reg_check("xfer", `SPIM_REG_XFER, 32'h0);
		report("busy protection", base);
	endtask

	task automatic axi_backpressure();
		axil_data_t d;
		axil_resp_t r;
		int base;
		base = total_errors();
		reg_write(`SPIM_REG_CTRL, 32'h0000_0105);
		axil_read(`SPIM_REG_CTRL, 6, d, r);
		check_resp("rresp", r, `SPIM_RESP_OKAY);
		check_data("ctrl", d, 32'h0000_0105);
		axil_write(`SPIM_REG_CS, 32'h2, 4'hf, 6, r);
		check_resp("bresp", r, `SPIM_RESP_OKAY);
		check_data("ncs", 32'(ncs), 32'h1);
		reg_check("cs", `SPIM_REG_CS, 32'h2);
		reg_write(`SPIM_REG_CS, 32'h0);
		report("back-pressure", base);
	endtask

	initial begin
		arst_n = 1'b0;
		axil_req = '0;
		model_en = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		regs_after_reset();
		buf_strobe_merge();
		loopback_xfer();
		external_xfer();
		busy_refusal();
		axi_backpressure();
		$display("%0d tests run, %0d errors", tests, total_errors());
		if (total_errors() == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: spim.f
+incdir+hw
hw/spim_pkg.sv
hw/spim_axil_slave.sv
hw/spim_ctrl_regs.sv
hw/spim_xfer_buf.sv
hw/spim_sequencer.sv
hw/spim_top.sv
sim/spim_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := spim_tb
FILELIST  := spim.f
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
